/* src/sched_pkg.sv */
/*
 * Shared widths, constants and packed payload structs for the scheduler.
 * Modules pull these in with a wildcard import in their header.
 */

package sched_pkg;

    // =====================================================================
    // Widths
    // =====================================================================
    localparam int XLEN          = 32;
    localparam int PHYS_TAG_BITS = 6;
    localparam int ROB_ID_BITS   = 5;
    localparam int AGE_BITS      = 4;
    localparam int NUM_WAKEUP    = 2;

    typedef logic [PHYS_TAG_BITS-1:0] phys_tag_t;

    // Execution unit select plus ALU function
    typedef struct packed {
        logic [1:0] exec_unit;
        logic [3:0] alu_op;
    } uop_t;

    // =====================================================================
    // Interface payloads
    // =====================================================================

    // One micro-op from rename, operand values already read
    typedef struct packed {
        logic                   valid;
        phys_tag_t              src1_tag;
        phys_tag_t              src2_tag;
        logic                   src1_ready;
        logic                   src2_ready;
        logic [XLEN-1:0]        src1_value;
        logic [XLEN-1:0]        src2_value;
        phys_tag_t              dest_tag;
        logic [ROB_ID_BITS-1:0] rob_id;
        uop_t                   uop;
    } alloc_req_t;

    // Result broadcast from execution
    typedef struct packed {
        logic            valid;
        phys_tag_t       tag;
        logic [XLEN-1:0] value;
    } wakeup_t;

    typedef struct packed {
        uop_t                   uop;
        logic [XLEN-1:0]        operand1;
        logic [XLEN-1:0]        operand2;
        phys_tag_t              dest_tag;
        logic [ROB_ID_BITS-1:0] rob_id;
    } issue_t;

endpackage

/* src/rs_entry_array.sv */
/*
 * Reservation station storage. Takes one allocation per cycle into the lowest
 * free slot, captures wakeup results, ages waiting entries and releases on issue.
 */
`timescale 1ns/1ps

module rs_entry_array import sched_pkg::*; #(
    parameter int RS_SIZE  = 8,
    localparam int IDX_BITS = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  alloc_req_t                            alloc,
    input  wakeup_t [NUM_WAKEUP-1:0]              wakeup,
    input  logic                                  issue_fire,
    input  logic [IDX_BITS-1:0]                   issue_index,
    output issue_t                                issue,
    output logic [RS_SIZE-1:0]                    ready_mask,
    output logic [RS_SIZE-1:0][AGE_BITS-1:0]      ages
);

    // Control state
    logic [RS_SIZE-1:0]                entry_valid;
    logic [RS_SIZE-1:0]                src1_ready;
    logic [RS_SIZE-1:0]                src2_ready;
    logic [RS_SIZE-1:0][AGE_BITS-1:0]  age_q;

    // Payload
    phys_tag_t                         src1_tag [RS_SIZE];
    phys_tag_t                         src2_tag [RS_SIZE];
    logic [XLEN-1:0]                   operand1 [RS_SIZE];
    logic [XLEN-1:0]                   operand2 [RS_SIZE];
    phys_tag_t                         dest_tag [RS_SIZE];
    logic [ROB_ID_BITS-1:0]            rob_id   [RS_SIZE];
    uop_t                              uop      [RS_SIZE];

    logic                              free_found;
    logic [IDX_BITS-1:0]               free_index;
    logic                              alloc_fire;
    logic [XLEN:0]                     alloc_op1;
    logic [XLEN:0]                     alloc_op2;
    logic [XLEN:0]                     op1_next [RS_SIZE];
    logic [XLEN:0]                     op2_next [RS_SIZE];

    // Ready flag in the top bit, operand value below it.
    // Tag zero is the hardwired zero register
    function automatic logic [XLEN:0] resolve_operand(
        input phys_tag_t               tag,
        input logic                    ready,
        input logic [XLEN-1:0]         value,
        input wakeup_t [NUM_WAKEUP-1:0] wk
    );
        logic            rdy;
        logic [XLEN-1:0] val;
        rdy = ready;
        val = value;
        if (tag == '0) begin
            rdy = 1'b1;
            val = '0;
        end
        for (int w = 0; w < NUM_WAKEUP; w++) begin
            if (!rdy && wk[w].valid && (wk[w].tag == tag)) begin
                rdy = 1'b1;
                val = wk[w].value;
            end
        end
        return {rdy, val};
    endfunction

    // =====================================================================
    // Free slot choice and operand resolution
    // =====================================================================
    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (!entry_valid[i] && !free_found) begin
                free_found = 1'b1;
                free_index = IDX_BITS'(i);
            end
        end
    end

    assign alloc_fire = alloc.valid && free_found;

    // Same-cycle wakeup is folded into the incoming operands
    assign alloc_op1 = resolve_operand(alloc.src1_tag, alloc.src1_ready, alloc.src1_value, wakeup);
    assign alloc_op2 = resolve_operand(alloc.src2_tag, alloc.src2_ready, alloc.src2_value, wakeup);

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            op1_next[i] = resolve_operand(src1_tag[i], src1_ready[i], operand1[i], wakeup);
            op2_next[i] = resolve_operand(src2_tag[i], src2_ready[i], operand2[i], wakeup);
            ready_mask[i] = entry_valid[i] && src1_ready[i] && src2_ready[i];
        end
    end

    assign ages = age_q;

    // =====================================================================
    // Control update
    // =====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
            src1_ready  <= '0;
            src2_ready  <= '0;
            age_q       <= '0;
        end else begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (entry_valid[i]) begin
                    src1_ready[i] <= op1_next[i][XLEN];
                    src2_ready[i] <= op2_next[i][XLEN];
                    if (age_q[i] != '1) begin
                        age_q[i] <= age_q[i] + 1'b1;
                    end
                end
            end
            if (alloc_fire) begin
                entry_valid[free_index] <= 1'b1;
                src1_ready[free_index]  <= alloc_op1[XLEN];
                src2_ready[free_index]  <= alloc_op2[XLEN];
                age_q[free_index]       <= '0;
            end
            // Slot is free again at this edge
            if (issue_fire) begin
                entry_valid[issue_index] <= 1'b0;
                age_q[issue_index]       <= '0;
            end
        end
    end

    // Payload write, including values captured from wakeups
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            operand1[i] <= op1_next[i][XLEN-1:0];
            operand2[i] <= op2_next[i][XLEN-1:0];
        end
        if (alloc_fire) begin
            src1_tag[free_index] <= alloc.src1_tag;
            src2_tag[free_index] <= alloc.src2_tag;
            operand1[free_index] <= alloc_op1[XLEN-1:0];
            operand2[free_index] <= alloc_op2[XLEN-1:0];
            dest_tag[free_index] <= alloc.dest_tag;
            rob_id[free_index]   <= alloc.rob_id;
            uop[free_index]      <= alloc.uop;
        end
    end

    // Read port for the selected entry
    assign issue.uop      = uop[issue_index];
    assign issue.operand1 = operand1[issue_index];
    assign issue.operand2 = operand2[issue_index];
    assign issue.dest_tag = dest_tag[issue_index];
    assign issue.rob_id   = rob_id[issue_index];

    // Rename must only allocate while it holds a credit
    assert property (@(posedge clk) disable iff (!rst_n) alloc.valid |-> free_found)
        else $error("allocation with no free entry");

endmodule

/* src/oldest_ready_select.sv */
/*
 * Picks the oldest ready entry of the reservation station in zero cycles.
 * Equal ages resolve to the lowest index.
 */
`timescale 1ns/1ps

module oldest_ready_select import sched_pkg::*; #(
    parameter int RS_SIZE  = 8,
    localparam int IDX_BITS = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1
) (
    input  logic [RS_SIZE-1:0]               ready_mask,
    input  logic [RS_SIZE-1:0][AGE_BITS-1:0] ages,
    output logic                             found,
    output logic [IDX_BITS-1:0]              index
);

    // Age of the current best candidate
    logic [AGE_BITS-1:0] best_age;

    // =====================================================================
    // Linear scan
    // =====================================================================
    // Strict compare keeps the earlier index on a tie, so the lowest
    // index wins among equal ages
    always_comb begin
        found    = 1'b0;
        index    = '0;
        best_age = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (ready_mask[i]) begin
                if (!found || (ages[i] > best_age)) begin
                    found    = 1'b1;
                    index    = IDX_BITS'(i);
                    best_age = ages[i];
                end
            end
        end
    end

endmodule

/* src/exec_credit_counter.sv */
/*
 * Credit counter for the execution side. Starts full, one credit per issue,
 * one back per return pulse. Issue is allowed while any credit remains.
 */
`timescale 1ns/1ps

module exec_credit_counter #(
    parameter int MAX_CREDITS = 2,
    localparam int CNT_BITS   = $clog2(MAX_CREDITS + 1)
) (
    input  logic clk,
    input  logic rst_n,
    input  logic consume,
    input  logic credit_return,
    output logic has_credit
);

    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= CNT_BITS'(MAX_CREDITS);
        end else begin
            // Consume and return together leave the count alone
            case ({consume, credit_return})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign has_credit = (count != '0);

    // Execution side returns no more than it was given
    assert property (@(posedge clk) disable iff (!rst_n)
        (credit_return && !consume) |-> (count < CNT_BITS'(MAX_CREDITS)))
        else $error("execution credit overflow");

    // Top level must gate issue with has_credit
    assert property (@(posedge clk) disable iff (!rst_n) consume |-> (count != '0))
        else $error("issue without execution credit");

endmodule

/* src/instruction_scheduler.sv */
/*
 * Single-issue out-of-order scheduler around one reservation station.
 * Credit flow control towards rename and towards execution.
 */
`timescale 1ns/1ps

module instruction_scheduler import sched_pkg::*; #(
    parameter int RS_SIZE      = 8,
    parameter int EXEC_CREDITS = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  alloc_req_t               alloc,
    input  wakeup_t [NUM_WAKEUP-1:0] wakeup,
    input  logic                     exec_credit_return,
    output issue_t                   issue,
    output logic                     issue_valid,
    output logic                     alloc_credit
);

    localparam int IDX_BITS = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

    logic [RS_SIZE-1:0]               ready_mask;
    logic [RS_SIZE-1:0][AGE_BITS-1:0] ages;
    logic                             found;
    logic [IDX_BITS-1:0]              issue_index;
    logic                             has_credit;
    logic                             issue_fire;

    // =====================================================================
    // Entry storage
    // =====================================================================
    rs_entry_array #(
        .RS_SIZE(RS_SIZE)
    ) rs_entry_array_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc      (alloc),
        .wakeup     (wakeup),
        .issue_fire (issue_fire),
        .issue_index(issue_index),
        .issue      (issue),
        .ready_mask (ready_mask),
        .ages       (ages)
    );

    oldest_ready_select #(
        .RS_SIZE(RS_SIZE)
    ) oldest_ready_select_inst (
        .ready_mask(ready_mask),
        .ages      (ages),
        .found     (found),
        .index     (issue_index)
    );

    exec_credit_counter #(
        .MAX_CREDITS(EXEC_CREDITS)
    ) exec_credit_counter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .consume      (issue_fire),
        .credit_return(exec_credit_return),
        .has_credit   (has_credit)
    );

    // =====================================================================
    // Issue handshake
    // =====================================================================
    // Execution always accepts when a credit is held
    assign issue_fire   = found && has_credit;
    assign issue_valid  = issue_fire;

    // Entry frees at the same edge it issues
    assign alloc_credit = issue_fire;

endmodule

/* verification/tb_instruction_scheduler.sv */
/*
 * Testbench for the instruction scheduler. Replays the per-cycle cases file,
 * driving inputs on the falling edge and checking the issue side before the next rising edge.
 */
`timescale 1ns/1ps

module tb_instruction_scheduler import sched_pkg::*; ();

    localparam int          RS_SIZE      = 8;
    localparam int          EXEC_CREDITS = 2;
    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 8;
    localparam int          FIELDS       = 24;
    localparam int          MAX_CASES    = 64;
    localparam logic [31:0] END_MARK     = 32'hff;

    logic                     clk = 1'b0;
    logic                     rst_n;
    alloc_req_t               alloc;
    wakeup_t [NUM_WAKEUP-1:0] wakeup;
    logic                     exec_credit_return;
    issue_t                   issue;
    logic                     issue_valid;
    logic                     alloc_credit;

    // Flat case table, FIELDS words per cycle
    logic [31:0] case_mem [MAX_CASES*FIELDS];
    // Operation sent with each allocation, looked up by ROB id at issue
    uop_t        uop_by_rob [2**ROB_ID_BITS];
    int          num_cases     = 0;
    int          errors        = 0;
    int          test_errors   = 0;
    int          tests_done    = 0;
    int          cycle_count   = 0;
    int          timeout_limit = MAX_CASES + 20;

    instruction_scheduler #(
        .RS_SIZE     (RS_SIZE),
        .EXEC_CREDITS(EXEC_CREDITS)
    ) instruction_scheduler_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .alloc             (alloc),
        .wakeup            (wakeup),
        .exec_credit_return(exec_credit_return),
        .issue             (issue),
        .issue_valid       (issue_valid),
        .alloc_credit      (alloc_credit)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // Run length bound, counted from reset release
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= timeout_limit) begin
                $display("Timeout: no end of the cases after %0d cycles", timeout_limit);
                $display("Finished with errors");
                $finish;
            end
        end
    end

    // ==================================================================
    // Helpers
    // ==================================================================
    task automatic clear_inputs();
        alloc              = '0;
        wakeup             = '0;
        exec_credit_return = 1'b0;
    endtask

    task automatic load_cases();
        $readmemh("verification/scheduler_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] != END_MARK) begin
            num_cases++;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, expected);
        errors++;
        test_errors++;
    endtask

    // Columns 1..17 of a case line onto the DUT inputs
    task automatic drive_case(input int n);
        int b;
        b = n * FIELDS;
        alloc.valid      = case_mem[b+1][0];
        alloc.src1_tag   = PHYS_TAG_BITS'(case_mem[b+2]);
        alloc.src2_tag   = PHYS_TAG_BITS'(case_mem[b+3]);
        alloc.src1_ready = case_mem[b+4][0];
        alloc.src2_ready = case_mem[b+5][0];
        alloc.src1_value = case_mem[b+6];
        alloc.src2_value = case_mem[b+7];
        alloc.dest_tag   = PHYS_TAG_BITS'(case_mem[b+8]);
        alloc.rob_id     = ROB_ID_BITS'(case_mem[b+9]);
        alloc.uop        = 6'(case_mem[b+10]);
        if (alloc.valid) begin
            uop_by_rob[alloc.rob_id] = alloc.uop;
        end
        for (int w = 0; w < NUM_WAKEUP; w++) begin
            wakeup[w].valid = case_mem[b+11+3*w][0];
            wakeup[w].tag   = PHYS_TAG_BITS'(case_mem[b+12+3*w]);
            wakeup[w].value = case_mem[b+13+3*w];
        end
        exec_credit_return = case_mem[b+17][0];
    endtask

    task automatic check_case(input int n);
        int   b;
        uop_t exp_uop;
        b = n * FIELDS;
        if (issue_valid !== case_mem[b+18][0]) begin
            report_mismatch("issue_valid", 32'(issue_valid), case_mem[b+18]);
        end
        if (alloc_credit !== case_mem[b+19][0]) begin
            report_mismatch("alloc_credit", 32'(alloc_credit), case_mem[b+19]);
        end
        // Payload only matters while an issue is expected
        if (case_mem[b+18][0]) begin
            exp_uop = uop_by_rob[ROB_ID_BITS'(case_mem[b+20])];
            if (32'(issue.rob_id) !== case_mem[b+20]) begin
                report_mismatch("issue.rob_id", 32'(issue.rob_id), case_mem[b+20]);
            end
            if (issue.operand1 !== case_mem[b+21]) begin
                report_mismatch("issue.operand1", issue.operand1, case_mem[b+21]);
            end
            if (issue.operand2 !== case_mem[b+22]) begin
                report_mismatch("issue.operand2", issue.operand2, case_mem[b+22]);
            end
            if (32'(issue.dest_tag) !== case_mem[b+23]) begin
                report_mismatch("issue.dest_tag", 32'(issue.dest_tag), case_mem[b+23]);
            end
            if (issue.uop !== exp_uop) begin
                report_mismatch("issue.uop", 32'(issue.uop), 32'(exp_uop));
            end
        end
    endtask

    // One case line per cycle, summary line when the test number changes
    task automatic run_cases();
        int test_num;
        for (int n = 0; n < num_cases; n++) begin
            @(negedge clk);
            test_num = int'(case_mem[n*FIELDS][7:0]);
            drive_case(n);
            #(CLK_PERIOD/4);
            check_case(n);
            if (n == num_cases - 1 || case_mem[(n+1)*FIELDS] != 32'(test_num)) begin
                $display("Test %0d done: %0d errors", test_num, test_errors);
                tests_done++;
                test_errors = 0;
            end
        end
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        clear_inputs();
        rst_n = 1'b0;
        load_cases();
        timeout_limit = num_cases + 20;
        if (num_cases == 0 || num_cases == MAX_CASES) begin
            $display("Case file could not be read or has no end marker line");
            $display("Finished with errors");
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            run_cases();
            $display("Summary: %0d tests, %0d cycles checked, %0d errors",
                     tests_done, num_cases, errors);
            if (errors == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
        end
        $finish;
    end

endmodule

/* build.f */
src/sched_pkg.sv
src/rs_entry_array.sv
src/oldest_ready_select.sv
src/exec_credit_counter.sv
src/instruction_scheduler.sv
verification/tb_instruction_scheduler.sv

/* Makefile */
# Verilator lint and simulation for the instruction scheduler.
# Every variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TB_TOP    ?= tb_instruction_scheduler
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Finished with errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log is searched for the fail line; a crashed run counts as a failure too
sim: build
	@./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/scheduler_cases.txt */
// test av s1t s2t s1r s2r s1val s2val dst rob uop  w0v w0t w0val  w1v w1t w1val  cret
// then expected: issue_valid alloc_credit rob_id operand1 operand2 dest_tag (hex, ff ends)
01 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
01 1 00 00 0 0 0055 0066 0a 01 11  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
01 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 01 000000 0000 0a
02 1 05 06 0 0 0000 0000 0b 02 12  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
02 0 00 00 0 0 0000 0000 00 00 00  1 05 001234  0 00 0000  0  0 0 00 000000 0000 00
02 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  1 06 5678  0  0 0 00 000000 0000 00
02 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 02 001234 5678 0b
02 1 07 00 0 1 0000 0000 0c 03 13  1 07 009abc  0 00 0000  0  0 0 00 000000 0000 00
02 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 03 009abc 0000 0c
03 1 10 00 0 1 0000 0000 0d 04 21  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
03 1 10 00 0 1 0000 0000 0e 05 21  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
03 1 10 00 0 1 0000 0000 0f 06 21  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
03 0 00 00 0 0 0000 0000 00 00 00  1 10 c0ffee  0 00 0000  0  0 0 00 000000 0000 00
03 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 04 c0ffee 0000 0d
03 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 05 c0ffee 0000 0e
03 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 06 c0ffee 0000 0f
04 1 00 00 1 1 0000 0000 10 07 31  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
04 1 00 00 1 1 0000 0000 11 08 31  0 00 000000  0 00 0000  0  1 1 07 000000 0000 10
04 1 00 00 1 1 0000 0000 12 09 31  0 00 000000  0 00 0000  0  1 1 08 000000 0000 11
04 1 00 00 1 1 0000 0000 13 0a 31  0 00 000000  0 00 0000  1  0 0 00 000000 0000 00
04 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 09 000000 0000 12
04 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 0a 000000 0000 13
04 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  0 0 00 000000 0000 00
05 1 20 00 0 1 0000 0000 21 10 02  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
05 1 20 00 0 1 0000 0000 22 11 02  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
05 1 20 00 0 1 0000 0000 23 12 02  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
05 1 20 00 0 1 0000 0000 24 13 02  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
05 1 20 00 0 1 0000 0000 25 14 02  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
05 1 20 00 0 1 0000 0000 26 15 02  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
05 1 20 00 0 1 0000 0000 27 16 02  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
05 1 20 00 0 1 0000 0000 28 17 02  1 20 000077  0 00 0000  0  0 0 00 000000 0000 00
05 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 10 000077 0000 21
05 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 11 000077 0000 22
05 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 12 000077 0000 23
05 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 13 000077 0000 24
05 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 14 000077 0000 25
05 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 15 000077 0000 26
05 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 16 000077 0000 27
05 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  1  1 1 17 000077 0000 28
ff 0 00 00 0 0 0000 0000 00 00 00  0 00 000000  0 00 0000  0  0 0 00 000000 0000 00
